// File: sources.f
verilog/frameBufferPkg.sv
verilog/tileRam.sv
verilog/fragmentLanes.sv
verilog/beatCounter.sv
verilog/tileControl.sv
verilog/controlRegs.sv
verilog/tileFrameBuffer.sv
test/clockGen.sv
test/tileFrameBufferTb.sv

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen
#(
    parameter int ResetCycles = 16
)
(
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset drops just after a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: test/tileFrameBufferTb.sv
`timescale 1ns/1ps

module tileFrameBufferTb;

    localparam int FrameSize = 64;
    localparam int StreamWidth = 32;
    localparam int PixelWidth = 16;
    localparam int PixelsPerBeat = StreamWidth / PixelWidth;
    localparam int Beats = FrameSize / PixelsPerBeat;
    localparam int IndexWidth = $clog2(FrameSize);
    localparam int CycleLimit = 40 * FrameSize + 2000;

    logic clk;
    logic reset;
    frameBufferPkg::apbReq_t apbReq;
    frameBufferPkg::apbRsp_t apbRsp;
    logic [IndexWidth-1:0] fragIndexWrite;
    logic [IndexWidth-1:0] fragIndexRead;
    frameBufferPkg::pixel_t fragIn;
    frameBufferPkg::pixel_t fragOut;
    frameBufferPkg::subMask_t fragMask;
    logic fragWriteEnable;
    logic mAxisTvalid;
    logic mAxisTready;
    logic mAxisTlast;
    logic [StreamWidth-1:0] mAxisTdata;

    // Expected memory contents with one entry per pixel
    frameBufferPkg::pixel_t shadow [FrameSize];

    logic [15:0] dataLfsr;
    logic [15:0] readyLfsr;
    int mismatchCount;
    int protocolCount;
    int cycleCount;
    int beatIndex;
    int framesSeen;

    clockGen clocks (
        .clk(clk),
        .reset(reset)
    );

    tileFrameBuffer i_dut (
        .clk(clk),
        .reset(reset),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .fragIndexWrite(fragIndexWrite),
        .fragIn(fragIn),
        .fragMask(fragMask),
        .fragWriteEnable(fragWriteEnable),
        .fragIndexRead(fragIndexRead),
        .fragOut(fragOut),
        .mAxisTvalid(mAxisTvalid),
        .mAxisTready(mAxisTready),
        .mAxisTlast(mAxisTlast),
        .mAxisTdata(mAxisTdata)
    );

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // Old pixel with the masked nibbles taken from the new one
    function automatic frameBufferPkg::pixel_t mergePixel(input frameBufferPkg::pixel_t oldPixel,
                                                          input frameBufferPkg::pixel_t newPixel,
                                                          input frameBufferPkg::subMask_t mask);
        frameBufferPkg::pixel_t result;
        result = oldPixel;
        for (int i = 0; i < 4; i++)
        begin
            if (mask[i])
            begin
                result[i*4 +: 4] = newPixel[i*4 +: 4];
            end
        end
        return result;
    endfunction

    // Lane 0 holds the lower pixel index of a beat
    function automatic logic [StreamWidth-1:0] expectedBeat(input int beat);
        logic [StreamWidth-1:0] result;
        for (int lane = 0; lane < PixelsPerBeat; lane++)
        begin
            result[lane*PixelWidth +: PixelWidth] = shadow[beat*PixelsPerBeat + lane];
        end
        return result;
    endfunction

    task automatic drawBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], dataLfsr[0]};
            dataLfsr = lfsrNext(dataLfsr);
        end
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected)
        begin
            mismatchCount++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic reportProtocol(input string what);
        protocolCount++;
        $display("Protocol error at %0t ns: %s", $time, what);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        tick();
        apbReq.paddr = addr;
        apbReq.pwdata = data;
        apbReq.pwrite = 1'b1;
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        tick();
        apbReq.penable = 1'b1;
        tick();
        apbReq.psel = 1'b0;
        apbReq.penable = 1'b0;
        apbReq.pwrite = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
        tick();
        apbReq.paddr = addr;
        apbReq.pwrite = 1'b0;
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        tick();
        apbReq.penable = 1'b1;
        @(negedge clk);
        data = apbRsp.prdata;
        tick();
        apbReq.psel = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    // Launch a command and poll the status register until it is done
    task automatic runCommand(input logic [31:0] cmdWord);
        logic [31:0] status;
        apbWrite(frameBufferPkg::CtrlAddr, cmdWord);
        do
        begin
            apbRead(frameBufferPkg::StatusAddr, status);
        end
        while (status[0]);
    endtask

    task automatic fragmentWriteRead(input int count);
        logic [31:0] bits;
        logic [IndexWidth-1:0] index;
        for (int n = 0; n < count; n++)
        begin
            drawBits(IndexWidth, bits);
            index = bits[IndexWidth-1:0];
            tick();
            fragIndexWrite = index;
            drawBits(16, bits);
            fragIn = bits[15:0];
            drawBits(4, bits);
            fragMask = bits[3:0];
            fragWriteEnable = 1'b1;
            tick();
            fragWriteEnable = 1'b0;
            fragIndexRead = index;
            shadow[index] = mergePixel(shadow[index], fragIn, fragMask);
            @(posedge clk);
            @(negedge clk);
            checkValue(fragOut, shadow[index], $sformatf("fragment read of pixel %0d", index));
        end
    endtask

    task automatic checkAllPixels(input string what);
        for (int i = 0; i < FrameSize; i++)
        begin
            tick();
            fragIndexRead = IndexWidth'(i);
            tick();
            @(negedge clk);
            checkValue(fragOut, shadow[i], $sformatf("%s, pixel %0d", what, i));
        end
    endtask

    task automatic fillShadow(input frameBufferPkg::pixel_t color);
        for (int i = 0; i < FrameSize; i++)
        begin
            shadow[i] = color;
        end
    endtask

    // Random tready from its own LFSR
    always @(posedge clk)
    begin
        #1;
        mAxisTready = readyLfsr[0];
        readyLfsr = lfsrNext(readyLfsr);
    end

    // Every stream transfer against the shadow memory
    always @(negedge clk)
    begin
        if (!reset && mAxisTvalid && mAxisTready)
        begin
            if (beatIndex >= Beats)
            begin
                reportProtocol($sformatf("stream carried beat %0d beyond one frame", beatIndex));
            end
            else
            begin
                checkValue(mAxisTdata, expectedBeat(beatIndex),
                           $sformatf("stream beat %0d", beatIndex));
            end
            if (mAxisTlast != (beatIndex == Beats - 1))
            begin
                reportProtocol($sformatf("tlast was %0b on beat %0d", mAxisTlast, beatIndex));
            end
            if (mAxisTlast)
            begin
                framesSeen++;
                beatIndex = 0;
            end
            else
            begin
                beatIndex++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] value;
        logic [31:0] bits;
        int framesBefore;
        apbReq = '0;
        fragIndexWrite = '0;
        fragIndexRead = '0;
        fragIn = '0;
        fragMask = '0;
        fragWriteEnable = 1'b0;
        mAxisTready = 1'b0;
        dataLfsr = 16'd3;
        readyLfsr = 16'd3;
        mismatchCount = 0;
        protocolCount = 0;
        cycleCount = 0;
        beatIndex = 0;
        framesSeen = 0;

        wait (!reset);
        tick();

        // State after reset
        checkValue(mAxisTvalid, 0, "tvalid after reset");
        checkValue(mAxisTlast, 0, "tlast after reset");
        apbRead(frameBufferPkg::StatusAddr, value);
        checkValue(value[0], 0, "busy after reset");
        apbRead(frameBufferPkg::ClearAddr, value);
        checkValue(value, 0, "clear colour after reset");

        // Memset with colour 0 gives known contents
        runCommand(32'h2);
        fillShadow('0);

        fragmentWriteRead(48);

        // Commit alone
        framesBefore = framesSeen;
        runCommand(32'h1);
        checkValue(framesSeen - framesBefore, 1, "frames streamed by a commit");
        checkValue(mAxisTvalid, 0, "tvalid after commit");

        // Memset with a random colour
        drawBits(16, bits);
        apbWrite(frameBufferPkg::ClearAddr, {16'h0, bits[15:0]});
        apbRead(frameBufferPkg::ClearAddr, value);
        checkValue(value, {16'h0, bits[15:0]}, "clear colour read back");
        runCommand(32'h2);
        fillShadow(bits[15:0]);
        checkAllPixels("after memset");

        // Commit then memset in one command
        fragmentWriteRead(16);
        drawBits(16, bits);
        apbWrite(frameBufferPkg::ClearAddr, {16'h0, bits[15:0]});
        framesBefore = framesSeen;
        runCommand(32'h3);
        checkValue(framesSeen - framesBefore, 1, "frames streamed by commit and memset");
        fillShadow(bits[15:0]);
        checkAllPixels("after commit and memset");

        // Second command while busy is dropped
        fragmentWriteRead(8);
        // A new clear colour makes a stray memset visible on every pixel
        apbWrite(frameBufferPkg::ClearAddr, {16'h0, ~bits[15:0]});
        framesBefore = framesSeen;
        apbWrite(frameBufferPkg::CtrlAddr, 32'h1);
        runCommand(32'h3);
        checkAllPixels("after dropped command");
        checkValue(framesSeen - framesBefore, 1, "frames with a dropped command");
        checkValue(beatIndex, 0, "beats left over after the last frame");

        $display("Errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolCount);
        if (mismatchCount == 0 && protocolCount == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/beatCounter.sv
`timescale 1ns/1ps

module beatCounter
#(
    parameter int BEATS = 32,
    localparam int CountWidth = (BEATS > 1) ? $clog2(BEATS) : 1
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  step,
    output logic [CountWidth-1:0] count,
    output logic [CountWidth-1:0] nextCount,
    output logic                  last
);
    localparam logic [CountWidth-1:0] LastBeat = CountWidth'(BEATS - 1);

    // Clear wins over step
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            count <= '0;
        end
        else if (step)
        begin
            count <= nextCount;
        end
    end

    // Wraps to zero past the last beat
    assign nextCount = count + 1'b1;
    assign last = (count == LastBeat);

endmodule

// File: verilog/controlRegs.sv
`timescale 1ns/1ps

module controlRegs
(
    input  logic                     clk,
    input  logic                     reset,
    input  frameBufferPkg::apbReq_t  apbReq,
    output frameBufferPkg::apbRsp_t  apbRsp,
    input  logic                     busy,
    output logic                     start,
    output frameBufferPkg::tileCmd_t cmd,
    output frameBufferPkg::pixel_t   clearColor
);
    localparam int PixelWidth = $bits(frameBufferPkg::pixel_t);
    localparam int CmdWidth = $bits(frameBufferPkg::tileCmd_t);

    logic access;
    logic writeAccess;

    // Access phase of an APB transfer
    assign access = apbReq.psel && apbReq.penable;
    assign writeAccess = access && apbReq.pwrite;

    assign cmd = frameBufferPkg::tileCmd_t'(apbReq.pwdata[CmdWidth-1:0]);

    // Launch only from idle, a command written while busy is lost
    assign start = writeAccess && (apbReq.paddr == frameBufferPkg::CtrlAddr)
                   && (cmd.commit || cmd.memset) && !busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clearColor <= '0;
        end
        else if (writeAccess && (apbReq.paddr == frameBufferPkg::ClearAddr))
        begin
            clearColor <= apbReq.pwdata[PixelWidth-1:0];
        end
    end

    // Read data is combinational so it is ready in the access cycle
    always_comb
    begin
        apbRsp.prdata = '0;
        case (apbReq.paddr)
            frameBufferPkg::ClearAddr:
            begin
                apbRsp.prdata[PixelWidth-1:0] = clearColor;
            end
            frameBufferPkg::StatusAddr:
            begin
                apbRsp.prdata[0] = busy;
            end
            default:
            begin
                apbRsp.prdata = '0;
            end
        endcase
    end

endmodule

// File: verilog/fragmentLanes.sv
`timescale 1ns/1ps

module fragmentLanes
#(
    parameter int FRAME_SIZE = 64,
    parameter int STREAM_WIDTH = 32,
    localparam int PixelWidth = $bits(frameBufferPkg::pixel_t),
    localparam int PixelsPerBeat = STREAM_WIDTH / PixelWidth,
    localparam int IndexWidth = $clog2(FRAME_SIZE),
    localparam int LaneBits = $clog2(PixelsPerBeat),
    localparam int BeatAddrWidth = (IndexWidth > LaneBits) ? IndexWidth - LaneBits : 1,
    localparam int StrobeWidth = STREAM_WIDTH / frameBufferPkg::SubPixelWidth
)
(
    input  logic                         clk,
    input  logic [IndexWidth-1:0]        fragIndexWrite,
    input  frameBufferPkg::pixel_t       fragIn,
    input  frameBufferPkg::subMask_t     fragMask,
    input  logic [IndexWidth-1:0]        fragIndexRead,
    input  logic [STREAM_WIDTH-1:0]      beatData,
    output logic [BeatAddrWidth-1:0]     laneAddrWrite,
    output logic [STREAM_WIDTH-1:0]      laneData,
    output logic [StrobeWidth-1:0]       laneStrobe,
    output logic [BeatAddrWidth-1:0]     laneAddrRead,
    output frameBufferPkg::pixel_t       fragOut
);
    localparam int LaneWidth = (LaneBits > 0) ? LaneBits : 1;
    localparam int MaskWidth = $bits(frameBufferPkg::subMask_t);

    typedef logic [LaneWidth-1:0] lane_t;
    typedef logic [BeatAddrWidth-1:0] beatAddr_t;

    lane_t writeLane;
    lane_t readLaneQ;

    // Low index bits pick the lane, the rest pick the beat
    assign writeLane = lane_t'(fragIndexWrite % PixelsPerBeat);
    assign laneAddrWrite = beatAddr_t'(fragIndexWrite / PixelsPerBeat);
    assign laneAddrRead = beatAddr_t'(fragIndexRead / PixelsPerBeat);

    assign laneData = {PixelsPerBeat{fragIn}};

    always_comb
    begin
        laneStrobe = '0;
        laneStrobe[writeLane*MaskWidth +: MaskWidth] = fragMask;
    end

    // Lane of the read follows the memory latency
    always_ff @(posedge clk)
    begin
        readLaneQ <= lane_t'(fragIndexRead % PixelsPerBeat);
    end

    assign fragOut = beatData[readLaneQ*PixelWidth +: PixelWidth];

endmodule

// File: verilog/frameBufferPkg.sv
package frameBufferPkg;

    // A pixel is four 4-bit sub-pixels
    localparam int SubPixelWidth = 4;
    localparam int SubPixels = 4;

    typedef logic [SubPixels*SubPixelWidth-1:0] pixel_t;
    typedef logic [SubPixels-1:0] subMask_t;

    typedef enum logic [1:0] {
        Idle,
        CommitInit,
        Commit,
        Memset
    } ctrlState_t;

    // Commit sits in bit 0, memset in bit 1 of the command word
    typedef struct packed {
        logic memset;
        logic commit;
    } tileCmd_t;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
    } apbRsp_t;

    // Register map
    localparam logic [7:0] CtrlAddr = 8'h00;
    localparam logic [7:0] ClearAddr = 8'h04;
    localparam logic [7:0] StatusAddr = 8'h08;

endpackage

// File: verilog/tileControl.sv
`timescale 1ns/1ps

module tileControl
#(
    parameter int BEATS = 32,
    localparam int CountWidth = (BEATS > 1) ? $clog2(BEATS) : 1
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  frameBufferPkg::tileCmd_t cmd,
    output logic                     busy,
    input  logic                     tready,
    output logic                     tvalid,
    output logic                     tlast,
    input  logic [CountWidth-1:0]    count,
    input  logic [CountWidth-1:0]    nextCount,
    input  logic                     last,
    output logic                     counterClear,
    output logic                     counterStep,
    output logic                     cmdOwnsPort,
    output logic                     ramWrite,
    output logic                     readSelectNext
);
    localparam logic [CountWidth-1:0] LastBeat = CountWidth'(BEATS - 1);

    frameBufferPkg::ctrlState_t state;
    logic memsetAfter;
    logic transfer;
    logic inCommit;

    assign transfer = tvalid && tready;
    assign inCommit = (state == frameBufferPkg::Commit);

    assign busy = (state != frameBufferPkg::Idle);
    assign cmdOwnsPort = busy;
    assign ramWrite = (state == frameBufferPkg::Memset);

    // Counter sits at zero while idle and again before a chained memset
    assign counterClear = (state == frameBufferPkg::Idle) || (inCommit && transfer && last);
    assign counterStep = (inCommit && transfer) || ramWrite;

    // On a handshake the memory fetches the following beat
    assign readSelectNext = inCommit && transfer;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= frameBufferPkg::Idle;
            memsetAfter <= 1'b0;
            tvalid <= 1'b0;
            tlast <= 1'b0;
        end
        else
        begin
            case (state)
                frameBufferPkg::Idle:
                begin
                    if (start)
                    begin
                        memsetAfter <= cmd.memset;
                        // Commit goes first when both bits are set
                        if (cmd.commit)
                        begin
                            state <= frameBufferPkg::CommitInit;
                        end
                        else
                        begin
                            state <= frameBufferPkg::Memset;
                        end
                    end
                end
                frameBufferPkg::CommitInit:
                begin
                    // Beat zero is being fetched in this cycle
                    tvalid <= 1'b1;
                    tlast <= (count == LastBeat);
                    state <= frameBufferPkg::Commit;
                end
                frameBufferPkg::Commit:
                begin
                    if (transfer)
                    begin
                        if (last)
                        begin
                            tvalid <= 1'b0;
                            tlast <= 1'b0;
                            state <= memsetAfter ? frameBufferPkg::Memset : frameBufferPkg::Idle;
                        end
                        else
                        begin
                            tlast <= (nextCount == LastBeat);
                        end
                    end
                end
                frameBufferPkg::Memset:
                begin
                    if (last)
                    begin
                        state <= frameBufferPkg::Idle;
                    end
                end
                default:
                begin
                    state <= frameBufferPkg::Idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/tileFrameBuffer.sv
`timescale 1ns/1ps

module tileFrameBuffer
#(
    parameter int FRAME_SIZE = 64,
    parameter int STREAM_WIDTH = 32,
    localparam int IndexWidth = $clog2(FRAME_SIZE)
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  frameBufferPkg::apbReq_t  apbReq,
    output frameBufferPkg::apbRsp_t  apbRsp,
    input  logic [IndexWidth-1:0]    fragIndexWrite,
    input  frameBufferPkg::pixel_t   fragIn,
    input  frameBufferPkg::subMask_t fragMask,
    input  logic                     fragWriteEnable,
    input  logic [IndexWidth-1:0]    fragIndexRead,
    output frameBufferPkg::pixel_t   fragOut,
    output logic                     mAxisTvalid,
    input  logic                     mAxisTready,
    output logic                     mAxisTlast,
    output logic [STREAM_WIDTH-1:0]  mAxisTdata
);
    localparam int PixelsPerBeat = STREAM_WIDTH / $bits(frameBufferPkg::pixel_t);
    localparam int Beats = FRAME_SIZE / PixelsPerBeat;
    localparam int BeatAddrWidth = (Beats > 1) ? $clog2(Beats) : 1;
    localparam int StrobeWidth = STREAM_WIDTH / frameBufferPkg::SubPixelWidth;

    typedef logic [BeatAddrWidth-1:0] beatAddr_t;
    typedef logic [STREAM_WIDTH-1:0] beat_t;
    typedef logic [StrobeWidth-1:0] strobe_t;

    logic start;
    logic busy;
    frameBufferPkg::tileCmd_t cmd;
    frameBufferPkg::pixel_t clearColor;

    beatAddr_t count;
    beatAddr_t nextCount;
    logic last;
    logic counterClear;
    logic counterStep;
    logic cmdOwnsPort;
    logic ramWrite;
    logic readSelectNext;

    beatAddr_t laneAddrWrite;
    beatAddr_t laneAddrRead;
    beat_t laneData;
    strobe_t laneStrobe;
    beat_t beatData;

    logic ramWriteEnable;
    beatAddr_t ramWriteAddr;
    beat_t ramWriteData;
    strobe_t ramWriteStrobe;
    beatAddr_t ramReadAddr;

    controlRegs regs (
        .clk(clk),
        .reset(reset),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .busy(busy),
        .start(start),
        .cmd(cmd),
        .clearColor(clearColor)
    );

    tileControl #(.BEATS(Beats)) control (
        .clk(clk),
        .reset(reset),
        .start(start),
        .cmd(cmd),
        .busy(busy),
        .tready(mAxisTready),
        .tvalid(mAxisTvalid),
        .tlast(mAxisTlast),
        .count(count),
        .nextCount(nextCount),
        .last(last),
        .counterClear(counterClear),
        .counterStep(counterStep),
        .cmdOwnsPort(cmdOwnsPort),
        .ramWrite(ramWrite),
        .readSelectNext(readSelectNext)
    );

    beatCounter #(.BEATS(Beats)) counter (
        .clk(clk),
        .reset(reset),
        .clear(counterClear),
        .step(counterStep),
        .count(count),
        .nextCount(nextCount),
        .last(last)
    );

    fragmentLanes #(.FRAME_SIZE(FRAME_SIZE), .STREAM_WIDTH(STREAM_WIDTH)) lanes (
        .clk(clk),
        .fragIndexWrite(fragIndexWrite),
        .fragIn(fragIn),
        .fragMask(fragMask),
        .fragIndexRead(fragIndexRead),
        .beatData(beatData),
        .laneAddrWrite(laneAddrWrite),
        .laneData(laneData),
        .laneStrobe(laneStrobe),
        .laneAddrRead(laneAddrRead),
        .fragOut(fragOut)
    );

    // The running command owns both memory ports, the fragment port is locked out
    always_comb
    begin
        if (cmdOwnsPort)
        begin
            ramWriteEnable = ramWrite;
            ramWriteAddr = count;
            ramWriteData = {PixelsPerBeat{clearColor}};
            ramWriteStrobe = '1;
            ramReadAddr = readSelectNext ? nextCount : count;
        end
        else
        begin
            ramWriteEnable = fragWriteEnable;
            ramWriteAddr = laneAddrWrite;
            ramWriteData = laneData;
            ramWriteStrobe = laneStrobe;
            ramReadAddr = laneAddrRead;
        end
    end

    tileRam #(.DEPTH(Beats), .WIDTH(STREAM_WIDTH)) ram (
        .clk(clk),
        .writeEnable(ramWriteEnable),
        .writeAddr(ramWriteAddr),
        .writeData(ramWriteData),
        .writeStrobe(ramWriteStrobe),
        .readAddr(ramReadAddr),
        .readData(beatData)
    );

    assign mAxisTdata = beatData;

endmodule

// File: verilog/tileRam.sv
`timescale 1ns/1ps

module tileRam
#(
    parameter int DEPTH = 32,
    parameter int WIDTH = 32,
    localparam int AddrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int StrobeWidth = WIDTH / frameBufferPkg::SubPixelWidth
)
(
    input  logic                   clk,
    input  logic                   writeEnable,
    input  logic [AddrWidth-1:0]   writeAddr,
    input  logic [WIDTH-1:0]       writeData,
    input  logic [StrobeWidth-1:0] writeStrobe,
    input  logic [AddrWidth-1:0]   readAddr,
    output logic [WIDTH-1:0]       readData
);
    localparam int NibbleWidth = frameBufferPkg::SubPixelWidth;

    typedef logic [WIDTH-1:0] word_t;

    word_t mem [DEPTH];

    // Each strobe bit guards one nibble of the word
    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            for (int i = 0; i < StrobeWidth; i++)
            begin
                if (writeStrobe[i])
                begin
                    mem[writeAddr][i*NibbleWidth +: NibbleWidth] <=
                        writeData[i*NibbleWidth +: NibbleWidth];
                end
            end
        end
    end

    // Registered read, returns the old word on a same-address write
    always_ff @(posedge clk)
    begin
        readData <= mem[readAddr];
    end

endmodule
